// File: sources.f
+incdir+rtl
rtl/front_pkg.sv
rtl/fetch_if.sv
rtl/pc_gen.sv
rtl/insn_fetch.sv
rtl/insn_decode.sv
rtl/front_top.sv
verif/front_tb.sv

// File: Makefile
# Verilator simulation of the instruction front end

OBJ_DIR = obj_dir

sim:
	verilator --binary --timing --assert -j 0 --top-module front_tb \
		-f sources.f -Mdir $(OBJ_DIR) -o front_sim
	./$(OBJ_DIR)/front_sim | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log

.PHONY: sim clean

// File: verif/front_tb.sv
/*
 * Testbench for the instruction front end
 *   cache model answering from a program table after random waits
 *   expected decode stream walked from the reset PC
 *   compare tasks for PC, instruction word, exception and flags
 *   test loop over freeze probabilities
 */

`timescale 1ns/1ps

`include "front_defines.svh"

module front_tb;
	import front_pkg::*;

	typedef struct packed {
		logic [31:0] adr;
		logic [31:0] dat;
		logic        err;
		logic [3:0]  tag;
	} prog_entry_t;

	localparam int PROG_LEN  = 12;
	localparam int EXP_LEN   = 32;
	localparam int NUM_TESTS = 3;

	// Program table: address, word, err flag, err tag
	localparam prog_entry_t PROG [PROG_LEN] = '{
		'{32'h0000_0100, 32'h9c20_0001, 1'b0, 4'h0},
		'{32'h0000_0104, 32'he063_1000, 1'b0, 4'h0},
		'{32'h0000_0108, 32'h8480_0004, 1'b0, 4'h0},
		// Looks like jal, but the fetch faults
		'{32'h0000_010c, 32'h0400_0010, 1'b1, 4'hd},
		// Looks like j, protection fault
		'{32'h0000_0110, 32'h0000_0004, 1'b1, 4'hc},
		'{32'h0000_0114, 32'ha860_0003, 1'b1, 4'hb},
		// Unknown tag
		'{32'h0000_0118, 32'he0a5_2800, 1'b1, 4'h7},
		// j forward by 8 words, lands on 0x13c
		'{32'h0000_011c, 32'h0000_0008, 1'b0, 4'h0},
		'{32'h0000_0120, 32'hdead_beef, 1'b0, 4'h0},
		'{32'h0000_013c, 32'ha860_0003, 1'b0, 4'h0},
		// 0x140 is unmapped; jal back by 16 words to 0x104
		'{32'h0000_0144, 32'h07ff_fff0, 1'b0, 4'h0},
		'{32'h0000_0148, 32'hbad0_0001, 1'b0, 4'h0}
	};

	// Freeze probability in percent, per test
	localparam int FREEZE_PCT [NUM_TESTS] = '{0, 25, 50};

	logic        clk;
	logic        rst_n_i;
	logic        icpu_req_o;
	logic [31:0] icpu_adr_o;
	logic [31:0] icpu_dat_i;
	logic        icpu_ack_i;
	logic        icpu_err_i;
	logic [3:0]  icpu_tag_i;
	logic        freeze_i;
	logic        dec_valid_o;
	logic [31:0] dec_pc_o;
	insn_t       dec_insn_o;
	exc_t        dec_exc_o;
	logic        dec_jump_o;

	// Expected decode stream
	logic [31:0] exp_pc   [EXP_LEN];
	insn_t       exp_insn [EXP_LEN];
	exc_t        exp_exc  [EXP_LEN];
	logic        exp_jump [EXP_LEN];

	int cache_wait;
	int error_count;

	front_top dut_i (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.icpu_req_o  (icpu_req_o),
		.icpu_adr_o  (icpu_adr_o),
		.icpu_dat_i  (icpu_dat_i),
		.icpu_ack_i  (icpu_ack_i),
		.icpu_err_i  (icpu_err_i),
		.icpu_tag_i  (icpu_tag_i),
		.freeze_i    (freeze_i),
		.dec_valid_o (dec_valid_o),
		.dec_pc_o    (dec_pc_o),
		.dec_insn_o  (dec_insn_o),
		.dec_exc_o   (dec_exc_o),
		.dec_jump_o  (dec_jump_o)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Program lookup and expected stream
	//////////////////////////////////////////////////////////////////////

	// Table index of an address, -1 when unmapped
	function automatic int find_entry(input logic [31:0] adr);
		int found;
		int i;
		found = -1;
		for (i = 0; i < PROG_LEN; i++) begin
			if (PROG[i].adr == adr) begin
				found = i;
			end
		end
		return found;
	endfunction

	function automatic exc_t tag_to_exc(input logic [3:0] tag);
		exc_t e;
		case (tag)
			`ITAG_TE: e = EXC_ITLB;
			`ITAG_PE: e = EXC_IMMU;
			default:  e = EXC_BUS;
		endcase
		return e;
	endfunction

	// Walk the program from the reset PC, following jumps
	task automatic build_expected();
		logic [31:0] pc;
		insn_t       word;
		int          idx;
		int          off_words;
		int          n;
		pc = `FRONT_RESET_PC;
		for (n = 0; n < EXP_LEN; n++) begin
			idx = find_entry(pc);
			exp_pc[n]  = pc;
			exp_exc[n] = EXC_NONE;
			if (idx < 0) begin
				word = insn_t'(`FRONT_NOP_INSN);
			end else if (PROG[idx].err) begin
				word = insn_t'(`FRONT_NOP_INSN);
				exp_exc[n] = tag_to_exc(PROG[idx].tag);
			end else begin
				word = insn_t'(PROG[idx].dat);
			end
			exp_insn[n] = word;
			exp_jump[n] = (word.j.opcode == `OPC_J) || (word.j.opcode == `OPC_JAL);
			if (exp_jump[n]) begin
				off_words = int'($signed(word.j.offset));
				pc = pc + 32'(off_words * 4);
			end else begin
				pc = pc + 32'd4;
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic fail_stop();
		error_count++;
		$display("Some tests failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_pc(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s got %h, expected %h", $time, what, got, exp);
			fail_stop();
		end
	endtask

	task automatic check_insn(input string what, input insn_t got, input insn_t exp);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s got %h, expected %h", $time, what, got, exp);
			fail_stop();
		end
	endtask

	task automatic check_exc(input string what, input exc_t got, input exc_t exp);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s got %s, expected %s", $time, what, got.name(), exp.name());
			fail_stop();
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s got %b, expected %b", $time, what, got, exp);
			fail_stop();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Cache model, reset and test run
	//////////////////////////////////////////////////////////////////////

	// Answers the address on the bus once the wait runs out
	task automatic drive_cache();
		int idx;
		icpu_ack_i = 1'b0;
		icpu_err_i = 1'b0;
		icpu_tag_i = 4'h0;
		icpu_dat_i = 32'h0;
		if (icpu_req_o) begin
			if (cache_wait > 0) begin
				cache_wait--;
			end else begin
				idx = find_entry(icpu_adr_o);
				if (idx < 0) begin
					icpu_dat_i = `FRONT_NOP_INSN;
					icpu_ack_i = 1'b1;
				end else begin
					icpu_dat_i = PROG[idx].dat;
					icpu_err_i = PROG[idx].err;
					icpu_ack_i = !PROG[idx].err;
					icpu_tag_i = PROG[idx].err ? PROG[idx].tag : 4'h0;
				end
				cache_wait = int'($urandom % 4);
			end
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#1;
		rst_n_i    = 1'b0;
		icpu_ack_i = 1'b0;
		icpu_err_i = 1'b0;
		freeze_i   = 1'b0;
		cache_wait = 0;
		repeat (10) begin
			@(negedge clk);
			check_bit("dec_valid_o in reset", dec_valid_o, 1'b0);
			check_bit("icpu_req_o in reset", icpu_req_o, 1'b0);
		end
		@(posedge clk);
		#1;
		rst_n_i = 1'b1;
	endtask

	// Each valid cycle is checked; freeze low means the word is taken
	task automatic run_test(input int pct);
		int taken;
		int cycles;
		int limit;
		taken  = 0;
		cycles = 0;
		limit  = EXP_LEN * 8 + 50;
		apply_reset();
		while (taken < EXP_LEN) begin
			@(posedge clk);
			#1;
			drive_cache();
			freeze_i = (int'($urandom % 100) < pct);
			@(negedge clk);
			if (cycles == 0) begin
				check_bit("dec_valid_o after reset", dec_valid_o, 1'b0);
				// First request goes out at the reset PC
				check_bit("icpu_req_o after reset", icpu_req_o, 1'b1);
				check_pc("icpu_adr_o after reset", icpu_adr_o, `FRONT_RESET_PC);
			end
			if (dec_valid_o) begin
				check_pc("dec_pc_o", dec_pc_o, exp_pc[taken]);
				check_insn("dec_insn_o", dec_insn_o, exp_insn[taken]);
				check_exc("dec_exc_o", dec_exc_o, exp_exc[taken]);
				check_bit("dec_jump_o", dec_jump_o, exp_jump[taken]);
				if (!freeze_i) begin
					taken++;
				end
			end else begin
				check_bit("dec_jump_o while idle", dec_jump_o, 1'b0);
			end
			cycles++;
			if (cycles >= limit) begin
				$display("Timeout: only %0d of %0d words decoded in %0d cycles",
					taken, EXP_LEN, cycles);
				fail_stop();
			end
		end
	endtask

	initial begin
		int t;
		rst_n_i     = 1'b0;
		icpu_dat_i  = 32'h0;
		icpu_ack_i  = 1'b0;
		icpu_err_i  = 1'b0;
		icpu_tag_i  = 4'h0;
		freeze_i    = 1'b0;
		cache_wait  = 0;
		error_count = 0;
		void'($urandom(9));
		build_expected();
		for (t = 0; t < NUM_TESTS; t++) begin
			$display("Test %0d: freeze probability %0d percent", t, FREEZE_PCT[t]);
			run_test(FREEZE_PCT[t]);
		end
		if (error_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: rtl/front_top.sv
/*
 * Instruction front end top level
 *   PC generator, fetch stage and decode stage
 *   plain cache port and downstream port
 *   fetch_if link between fetch and decode
 */

`timescale 1ns/1ps

module front_top (
	input  logic               clk,
	input  logic               rst_n_i,

	// Instruction cache port
	output logic               icpu_req_o,
	output logic [31:0]        icpu_adr_o,
	input  logic [31:0]        icpu_dat_i,
	input  logic               icpu_ack_i,
	input  logic               icpu_err_i,
	input  logic [3:0]         icpu_tag_i,

	// Downstream pipeline
	input  logic               freeze_i,
	output logic               dec_valid_o,
	output logic [31:0]        dec_pc_o,
	output front_pkg::insn_t   dec_insn_o,
	output front_pkg::exc_t    dec_exc_o,
	output logic               dec_jump_o
);

	// Fetch to PC generator
	logic        consume;
	// Decode to PC generator
	logic        redirect;
	logic [31:0] target;

	fetch_if fetch_link ();

	//////////////////////////////////////////////////////////////////////
	// Stages
	//////////////////////////////////////////////////////////////////////

	pc_gen pc_gen_i (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.consume_i  (consume),
		.redirect_i (redirect),
		.target_i   (target),
		.icpu_req_o (icpu_req_o),
		.icpu_adr_o (icpu_adr_o)
	);

	// Answer always belongs to the address on the bus
	insn_fetch insn_fetch_i (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.icpu_dat_i (icpu_dat_i),
		.icpu_ack_i (icpu_ack_i),
		.icpu_err_i (icpu_err_i),
		.icpu_tag_i (icpu_tag_i),
		.icpu_adr_i (icpu_adr_o),
		.consume_o  (consume),
		.fetch      (fetch_link.fetch)
	);

	insn_decode insn_decode_i (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.fetch       (fetch_link.decode),
		.freeze_i    (freeze_i),
		.redirect_o  (redirect),
		.target_o    (target),
		.dec_valid_o (dec_valid_o),
		.dec_pc_o    (dec_pc_o),
		.dec_insn_o  (dec_insn_o),
		.dec_exc_o   (dec_exc_o),
		.dec_jump_o  (dec_jump_o)
	);

endmodule

// File: rtl/insn_decode.sv
/*
 * Decode stage
 *   pipeline register for the consumed word
 *   opcode from the register view, offset from the jump view
 *   j/jal detection, target and redirect
 *   freeze and flush back to fetch
 */

`timescale 1ns/1ps

`include "front_defines.svh"

module insn_decode (
	input  logic               clk,
	input  logic               rst_n_i,
	fetch_if.decode            fetch,
	input  logic               freeze_i,
	output logic               redirect_o,
	output logic [31:0]        target_o,
	output logic               dec_valid_o,
	output logic [31:0]        dec_pc_o,
	output front_pkg::insn_t   dec_insn_o,
	output front_pkg::exc_t    dec_exc_o,
	output logic               dec_jump_o
);
	import front_pkg::*;

	// Decode register
	logic        valid_q;
	logic [31:0] pc_q;
	insn_t       insn_q;
	exc_t        exc_q;

	// Decoded fields
	opcode_t     opcode;
	jump_off_t   offset;
	logic        is_jump;
	logic        jump_pending;

	//////////////////////////////////////////////////////////////////////
	// Pipeline register
	//////////////////////////////////////////////////////////////////////

	// Flushed fetches arrive here with valid already low
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_q <= 1'b0;
		end else if (!freeze_i) begin
			valid_q <= fetch.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze_i && fetch.valid) begin
			pc_q   <= fetch.pc;
			insn_q <= fetch.insn;
			exc_q  <= fetch.exc;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Field split and jump target
	//////////////////////////////////////////////////////////////////////

	// Opcode read through the register format
	assign opcode = insn_q.r.opcode;
	// Offset read through the jump format
	assign offset = insn_q.j.offset;

	assign is_jump = (opcode == `OPC_J) || (opcode == `OPC_JAL);

	// Word offset, sign-extended and scaled by four
	assign target_o = pc_q + {{4{offset[25]}}, offset, 2'b00};

	// Faulted words never steer the front end
	assign jump_pending = valid_q & is_jump & (exc_q == EXC_NONE);

	// Held while frozen, fires once freeze drops
	assign redirect_o = jump_pending & !freeze_i;

	//////////////////////////////////////////////////////////////////////
	// Outputs and back channel
	//////////////////////////////////////////////////////////////////////

	assign dec_valid_o = valid_q;
	assign dec_pc_o    = pc_q;
	assign dec_insn_o  = insn_q;
	assign dec_exc_o   = exc_q;
	assign dec_jump_o  = valid_q & is_jump;

	assign fetch.freeze = freeze_i;
	// Word behind the jump is squashed
	assign fetch.flush  = redirect_o;

	// Redirect needs a valid word, and leaves a bubble behind it
	assert property (@(posedge clk) disable iff (!rst_n_i)
		redirect_o |-> dec_valid_o ##1 !dec_valid_o);

endmodule

// File: rtl/insn_fetch.sv
/*
 * Instruction fetch stage
 *   live answer path from the cache, combinational to decode
 *   one-entry save register for answers taken under freeze
 *   err tag classification and NOP substitution
 *   squash of the current fetch on flush
 */

`timescale 1ns/1ps

`include "front_defines.svh"

module insn_fetch (
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic [31:0] icpu_dat_i,
	input  logic        icpu_ack_i,
	input  logic        icpu_err_i,
	input  logic [3:0]  icpu_tag_i,
	input  logic [31:0] icpu_adr_i,
	output logic        consume_o,
	fetch_if.fetch      fetch
);
	import front_pkg::*;

	// Live answer
	logic        answer;
	insn_t       live_insn;
	logic [31:0] live_pc;
	exc_t        live_exc;

	// Save register
	logic        save;
	logic        saved_q;
	insn_t       insn_saved_q;
	logic [31:0] pc_saved_q;
	exc_t        exc_saved_q;

	//////////////////////////////////////////////////////////////////////
	// Live answer decode
	//////////////////////////////////////////////////////////////////////

	assign answer = icpu_ack_i | icpu_err_i;

	// Faulted fetch carries no usable word
	assign live_insn = icpu_err_i ? insn_t'(`FRONT_NOP_INSN) : insn_t'(icpu_dat_i);
	assign live_pc   = {icpu_adr_i[31:2], 2'b00};

	// Tag to exception, unknown tags fall to bus error
	always_comb begin
		live_exc = EXC_NONE;
		if (icpu_err_i) begin
			case (icpu_tag_i)
				`ITAG_TE: live_exc = EXC_ITLB;
				`ITAG_PE: live_exc = EXC_IMMU;
				`ITAG_BE: live_exc = EXC_BUS;
				default:  live_exc = EXC_BUS;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Save under freeze
	//////////////////////////////////////////////////////////////////////

	// Only one entry; a second answer while saved is dropped
	assign save = answer & fetch.freeze & !saved_q & !fetch.flush;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			saved_q <= 1'b0;
		end else if (fetch.flush) begin
			saved_q <= 1'b0;
		end else if (save) begin
			saved_q <= 1'b1;
		end else if (!fetch.freeze) begin
			// Saved word leaves in this cycle
			saved_q <= 1'b0;
		end
	end

	// Payload of the entry
	always_ff @(posedge clk) begin
		if (save) begin
			insn_saved_q <= live_insn;
			pc_saved_q   <= live_pc;
			exc_saved_q  <= live_exc;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Output toward decode
	//////////////////////////////////////////////////////////////////////

	assign fetch.valid = (saved_q | answer) & !fetch.flush;
	assign fetch.insn  = saved_q ? insn_saved_q : live_insn;
	assign fetch.pc    = saved_q ? pc_saved_q : live_pc;
	assign fetch.exc   = saved_q ? exc_saved_q : live_exc;

	// PC generator steps only when decode takes the word
	assign consume_o = fetch.valid & !fetch.freeze;

	// Flush kills this cycle and empties the entry
	assert property (@(posedge clk) disable iff (!rst_n_i)
		fetch.flush |-> !fetch.valid ##1 !saved_q);

	// A save is visible at the next edge
	assert property (@(posedge clk) disable iff (!rst_n_i)
		save |=> saved_q);

	// Ack never carries an exception, live or after saving
	assert property (@(posedge clk) disable iff (!rst_n_i)
		(icpu_ack_i && !saved_q) |->
			(fetch.exc == EXC_NONE) ##1 (!saved_q || fetch.exc == EXC_NONE));

endmodule

// File: rtl/pc_gen.sv
/*
 * Program counter generator
 *   fetch request flag, raised once reset is released
 *   word address, stepped on consumed answers
 *   target load on a jump redirect
 */

`timescale 1ns/1ps

`include "front_defines.svh"

module pc_gen (
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic        consume_i,
	input  logic        redirect_i,
	input  logic [31:0] target_i,
	output logic        icpu_req_o,
	output logic [31:0] icpu_adr_o
);

	logic        req_q;
	logic [31:0] adr_q;
	logic [31:0] adr_next;

	//////////////////////////////////////////////////////////////////////
	// Request flag
	//////////////////////////////////////////////////////////////////////

	// Low through reset, then always requesting
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			req_q <= 1'b0;
		end else begin
			req_q <= 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Fetch address
	//////////////////////////////////////////////////////////////////////

	// Redirect wins over a consumed answer
	always_comb begin
		adr_next = adr_q;
		if (redirect_i) begin
			// Targets are forced to a word boundary
			adr_next = {target_i[31:2], 2'b00};
		end else if (consume_i) begin
			adr_next = adr_q + 32'd4;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			adr_q <= `FRONT_RESET_PC;
		end else begin
			adr_q <= adr_next;
		end
	end

	assign icpu_req_o = req_q;
	assign icpu_adr_o = adr_q;

	// Pending request keeps its address until answered or redirected
	assert property (@(posedge clk) disable iff (!rst_n_i)
		(icpu_req_o && !consume_i && !redirect_i) |=> $stable(icpu_adr_o));

endmodule

// File: rtl/fetch_if.sv
/*
 * Link between fetch and decode
 *   fetched word, its PC and exception going forward
 *   freeze and flush coming back
 */

`timescale 1ns/1ps

interface fetch_if;
	import front_pkg::*;

	// Forward, driven by fetch
	logic        valid;
	insn_t       insn;
	logic [31:0] pc;
	exc_t        exc;

	// Backward, driven by decode
	logic        freeze;
	logic        flush;

	modport fetch (
		output valid, insn, pc, exc,
		input  freeze, flush
	);

	modport decode (
		input  valid, insn, pc, exc,
		output freeze, flush
	);

endinterface

// File: rtl/front_pkg.sv
/*
 * Front end types
 *   instruction field types and the two instruction views
 *   insn_t union over one 32-bit word
 *   exc_t fetch exception code
 */

package front_pkg;

	// Field types
	typedef logic [5:0]  opcode_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [10:0] func_t;
	typedef logic [25:0] jump_off_t;

	// Jump format, signed word offset below the opcode
	typedef struct packed {
		opcode_t   opcode;
		jump_off_t offset;
	} jump_view_t;

	// Register format
	typedef struct packed {
		opcode_t  opcode;
		reg_idx_t rd;
		reg_idx_t ra;
		reg_idx_t rb;
		func_t    func;
	} reg_view_t;

	// Same word, two readings; opcode sits in bits 31:26 in both
	typedef union packed {
		jump_view_t j;
		reg_view_t  r;
	} insn_t;

	// Fetch exception attached to a word
	typedef enum logic [1:0] {
		EXC_NONE = 2'd0,
		EXC_ITLB = 2'd1,
		EXC_IMMU = 2'd2,
		EXC_BUS  = 2'd3
	} exc_t;

endpackage

// File: rtl/front_defines.svh
/*
 * Shared constants of the instruction front end
 *   reset fetch address and the NOP filler word
 *   cache error tag codes
 *   opcodes of the unconditional jumps
 */

`ifndef FRONT_DEFINES_SVH
`define FRONT_DEFINES_SVH

// First fetch address after reset
`define FRONT_RESET_PC  32'h0000_0100

// l.nop with opcode 0x05, stands in for a faulted fetch
`define FRONT_NOP_INSN  32'h1500_0000

// Error tags returned by the cache with err
`define ITAG_TE         4'hd
`define ITAG_PE         4'hc
`define ITAG_BE         4'hb

// Jump opcodes, j and jal
`define OPC_J           6'h00
`define OPC_JAL         6'h01

`endif
